// File: build.f
logic/ipb_pkg.sv
logic/io_bus_if.sv
logic/ipb_io_fsm.sv
logic/io_readback_mux.sv
logic/channel_ctrl.sv
logic/serial_shifter.sv
logic/afe_dac_port.sv
logic/clk_synth_port.sv
logic/all_channels.sv
verification/all_channels_assert.sv
verification/all_channels_tb.sv

// File: Makefile
.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator, run it, check the log"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --timing --assert --timescale 1ns/100ps -f build.f \
		--top-module all_channels_tb -Mdir obj_dir -o all_channels_sim
	./obj_dir/all_channels_sim | tee sim.log
	grep -q "All tests passed" sim.log

clean:
	rm -rf obj_dir sim.log

// File: verification/all_channels_tb.sv
/* directed tests of the register fabric; inputs change on the falling edge
   and outputs are sampled there too, serial bits at each rising serial clock */
`default_nettype none

module all_channels_tb;
  timeunit 1ns;
  timeprecision 100ps;
  import ipb_pkg::*;

  localparam int unsigned RNG_SEED  = 32'h61c9;
  localparam int NUM_TESTS          = 6;
  localparam int ANSWER_LIMIT       = IO_TIMEOUT + 8;               // cycles to ack/err
  localparam int START_LIMIT        = 32;                           // cycles to frame start
  localparam int FRAME_LIMIT        = 2 * SYNTH_FRAME_BITS * SCLK_DIV + 16;
  localparam int WATCHDOG_CYCLES    = NUM_TESTS * 2 * SYNTH_FRAME_BITS * SCLK_DIV + 200;

  logic                ipb_clk;
  logic                rst_n;
  logic                ipb_strobe;
  logic                ipb_write;
  ipb_addr_t           ipb_addr;
  ipb_data_t           ipb_wdata;
  ipb_data_t           ipb_rdata;
  logic                ipb_ack;
  logic                ipb_err;
  logic [NUM_CHAN-1:0] readout_pause;
  logic                adcclk_dclk;
  logic                adcclk_ddat;
  logic                adcclk_dlen;
  logic                adcclk_sync;
  logic                afe_dac_sclk;
  logic                afe_dac_sdi;
  logic                afe_dac_sync_n;

  int        errors;
  int        checks;
  ipb_data_t ctrl_model    [NUM_CHAN];  // expected channel registers
  ipb_data_t scratch_model [NUM_CHAN];

  all_channels dut_i (
    .ipb_clk        (ipb_clk),
    .rst_n          (rst_n),
    .ipb_strobe     (ipb_strobe),
    .ipb_write      (ipb_write),
    .ipb_addr       (ipb_addr),
    .ipb_wdata      (ipb_wdata),
    .ipb_rdata      (ipb_rdata),
    .ipb_ack        (ipb_ack),
    .ipb_err        (ipb_err),
    .readout_pause  (readout_pause),
    .adcclk_dclk    (adcclk_dclk),
    .adcclk_ddat    (adcclk_ddat),
    .adcclk_dlen    (adcclk_dlen),
    .adcclk_sync    (adcclk_sync),
    .afe_dac_sclk   (afe_dac_sclk),
    .afe_dac_sdi    (afe_dac_sdi),
    .afe_dac_sync_n (afe_dac_sync_n)
  );

  initial ipb_clk = 1'b0;
  always #5 ipb_clk = ~ipb_clk;         // 10 ns period

  ////////////////////////////////////////////////////////////////////////////
  // compare tasks
  task automatic check_data(input string name, input ipb_data_t exp, input ipb_data_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("FAIL %0t %s expected %h actual %h", $time, name, exp, act);
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("FAIL %0t %s expected %b actual %b", $time, name, exp, act);
    end
  endtask

  // only the low exp_bits of the word go out on the wire
  task automatic check_frame(input string name, input ipb_data_t exp, input ipb_data_t act,
                             input int exp_bits, input int act_bits);
    ipb_data_t mask;
    mask = '1;
    mask = mask >> (32 - exp_bits);
    checks++;
    if (act_bits != exp_bits) begin
      errors++;
      $display("FAIL %0t %s bit count expected %0d actual %0d", $time, name,
               exp_bits, act_bits);
    end else if ((act & mask) !== (exp & mask)) begin
      errors++;
      $display("FAIL %0t %s expected %h actual %h", $time, name, exp & mask, act & mask);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // bus access
  function automatic ipb_addr_t make_addr(input io_region_e region, input io_addr_t offset);
    return {region, offset};
  endfunction

  task automatic bus_access(input logic wr, input ipb_addr_t addr, input ipb_data_t wdata,
                            output ipb_data_t rdata, output logic acked, output logic erred);
    int waited;
    @(negedge ipb_clk);
    ipb_strobe = 1'b1;
    ipb_write  = wr;
    ipb_addr   = addr;
    ipb_wdata  = wdata;
    acked      = 1'b0;
    erred      = 1'b0;
    waited     = 0;
    while (!acked && !erred && waited < ANSWER_LIMIT) begin
      @(negedge ipb_clk);
      acked = ipb_ack;
      erred = ipb_err;
      waited++;
    end
    rdata      = ipb_rdata;             // valid with ack
    ipb_strobe = 1'b0;
    ipb_write  = 1'b0;
    if (!acked && !erred) begin
      errors++;
      $display("Access to address %h got neither ipb_ack nor ipb_err within %0d cycles",
               addr, ANSWER_LIMIT);
    end
    @(negedge ipb_clk);                 // FSM leaves HOLD before the next strobe
  endtask

  task automatic ipb_write_word(input ipb_addr_t addr, input ipb_data_t data);
    ipb_data_t unused_rd;
    logic      acked;
    logic      erred;
    bus_access(1'b1, addr, data, unused_rd, acked, erred);
    if (erred) begin
      errors++;
      $display("Write to address %h ended with ipb_err instead of ipb_ack", addr);
    end
  endtask

  task automatic ipb_read_word(input ipb_addr_t addr, output ipb_data_t data);
    logic acked;
    logic erred;
    bus_access(1'b0, addr, '0, data, acked, erred);
    if (erred) begin
      errors++;
      $display("Read of address %h ended with ipb_err instead of ipb_ack", addr);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // serial capture from the DAC or the synth pins
  function automatic logic frame_on(input logic synth);
    return synth ? adcclk_dlen : ~afe_dac_sync_n;
  endfunction

  function automatic logic ser_clk(input logic synth);
    return synth ? adcclk_dclk : afe_dac_sclk;
  endfunction

  function automatic logic ser_dat(input logic synth);
    return synth ? adcclk_ddat : afe_dac_sdi;
  endfunction

  task automatic capture_frame(input logic synth, output ipb_data_t bits, output int count);
    int   waited;
    logic prev_clk;
    bits   = '0;
    count  = 0;
    waited = 0;
    while (!frame_on(synth) && waited < START_LIMIT) begin
      @(negedge ipb_clk);
      waited++;
    end
    if (!frame_on(synth)) begin
      errors++;
      $display("Serial frame on the %s port did not start within %0d cycles",
               synth ? "synth" : "DAC", START_LIMIT);
    end else begin
      prev_clk = ser_clk(synth);
      waited   = 0;
      while (frame_on(synth) && waited < FRAME_LIMIT) begin
        if (ser_clk(synth) && !prev_clk) begin
          bits = {bits[30:0], ser_dat(synth)};   // MSB arrives first
          count++;
        end
        prev_clk = ser_clk(synth);
        @(negedge ipb_clk);
        waited++;
      end
      if (frame_on(synth)) begin
        errors++;
        $display("Serial frame on the %s port did not end within %0d cycles",
                 synth ? "synth" : "DAC", FRAME_LIMIT);
      end
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // directed tests
  task automatic reset_outputs();
    for (int i = 0; i < NUM_CHAN; i++) begin
      check_bit($sformatf("readout_pause[%0d]", i), 1'b0, readout_pause[i]);
    end
    check_bit("afe_dac_sync_n", 1'b1, afe_dac_sync_n);
    check_bit("afe_dac_sclk", 1'b0, afe_dac_sclk);
    check_bit("adcclk_dlen", 1'b0, adcclk_dlen);
    check_bit("adcclk_dclk", 1'b0, adcclk_dclk);
    check_bit("adcclk_sync", 1'b0, adcclk_sync);
  endtask

  task automatic verify_channel(input int i);
    ipb_data_t rd;
    ipb_read_word(make_addr(io_region_e'(4'(i)), REG_CTRL), rd);
    check_data($sformatf("chan%0d ctrl", i), ctrl_model[i], rd);
    ipb_read_word(make_addr(io_region_e'(4'(i)), REG_SCRATCH), rd);
    check_data($sformatf("chan%0d scratch", i), scratch_model[i], rd);
    check_bit($sformatf("readout_pause[%0d]", i), ctrl_model[i][0], readout_pause[i]);
  endtask

  task automatic channel_regs_rw();
    for (int i = 0; i < NUM_CHAN; i++) begin
      ctrl_model[i]    = $urandom;
      scratch_model[i] = $urandom;
      ipb_write_word(make_addr(io_region_e'(4'(i)), REG_CTRL), ctrl_model[i]);
      ipb_write_word(make_addr(io_region_e'(4'(i)), REG_SCRATCH), scratch_model[i]);
      verify_channel(i);
    end
  endtask

  task automatic region_isolation();
    ctrl_model[2]    = ~ctrl_model[2];          // flips pause too
    scratch_model[2] = ~scratch_model[2];
    ipb_write_word(make_addr(REGION_CHAN2, REG_CTRL), ctrl_model[2]);
    ipb_write_word(make_addr(REGION_CHAN2, REG_SCRATCH), scratch_model[2]);
    for (int i = 0; i < NUM_CHAN; i++) begin
      verify_channel(i);
    end
  endtask

  task automatic reserved_region_err();
    ipb_data_t rd;
    logic      acked;
    logic      erred;
    bus_access(1'b0, {4'd7, REG_CTRL}, '0, rd, acked, erred);
    check_bit("ipb_err on region 7", 1'b1, erred);
    check_bit("ipb_ack on region 7", 1'b0, acked);
    ipb_read_word(make_addr(REGION_CHAN0, REG_SCRATCH), rd);   // bus still alive
    check_data("chan0 scratch after err", scratch_model[0], rd);
  endtask

  task automatic dac_frame_shift();
    ipb_data_t word;
    ipb_data_t got;
    ipb_data_t status;
    int        nbits;
    word = $urandom;
    fork
      capture_frame(1'b0, got, nbits);
      begin
        ipb_write_word(make_addr(REGION_AFE_DAC, REG_SHIFT_WORD), word);
        ipb_read_word(make_addr(REGION_AFE_DAC, REG_STATUS), status);
        check_data("afe_dac status during frame", 32'd1, status);
      end
    join
    check_frame("afe_dac_sdi", word, got, DAC_FRAME_BITS, nbits);
    ipb_read_word(make_addr(REGION_AFE_DAC, REG_STATUS), status);
    check_data("afe_dac status after frame", 32'd0, status);
    check_bit("afe_dac_sync_n after frame", 1'b1, afe_dac_sync_n);
  endtask

  task automatic synth_frame_shift();
    ipb_data_t word_a;
    ipb_data_t word_b;
    ipb_data_t got;
    ipb_data_t rd;
    int        nbits;
    word_a = $urandom;
    word_b = ~word_a;                           // sent while busy so dropped
    fork
      capture_frame(1'b1, got, nbits);
      begin
        ipb_write_word(make_addr(REGION_CLK_SYNTH, REG_SHIFT_WORD), word_a);
        ipb_read_word(make_addr(REGION_CLK_SYNTH, REG_STATUS), rd);
        check_data("adcclk status during frame", 32'd1, rd);
        ipb_write_word(make_addr(REGION_CLK_SYNTH, REG_SHIFT_WORD), word_b);
      end
    join
    check_frame("adcclk_ddat", word_a, got, SYNTH_FRAME_BITS, nbits);
    ipb_read_word(make_addr(REGION_CLK_SYNTH, REG_SHIFT_WORD), rd);
    check_data("adcclk shift word", word_a, rd);
    ipb_read_word(make_addr(REGION_CLK_SYNTH, REG_STATUS), rd);
    check_data("adcclk status after frame", 32'd0, rd);
    check_bit("adcclk_dlen after frame", 1'b0, adcclk_dlen);
    ipb_write_word(make_addr(REGION_CLK_SYNTH, REG_SYNC), 32'd1);
    check_bit("adcclk_sync", 1'b1, adcclk_sync);
    ipb_read_word(make_addr(REGION_CLK_SYNTH, REG_SYNC), rd);
    check_data("adcclk sync reg", 32'd1, rd);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // sequence and summary
  initial begin
    int unsigned rng_init;
    rng_init   = $urandom(RNG_SEED);          // seeds the generator once
    errors     = 0;
    checks     = 0;
    rst_n      = 1'b0;
    ipb_strobe = 1'b0;
    ipb_write  = 1'b0;
    ipb_addr   = '0;
    ipb_wdata  = '0;
    repeat (2) @(posedge ipb_clk);
    @(negedge ipb_clk);
    rst_n = 1'b1;

    reset_outputs();
    channel_regs_rw();
    region_isolation();
    reserved_region_err();
    dac_frame_shift();
    synth_frame_shift();

    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

  // hard stop if a test never returns
  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge ipb_clk);
    $display("Watchdog expired after %0d cycles, the tests did not finish", WATCHDOG_CYCLES);
    $display("Some tests failed");
    $finish;
  end

endmodule

`default_nettype wire

// File: verification/all_channels_assert.sv
/* handshake checks bound into all_channels; dac_busy is taken from the DAC port
   all checks are off while rst_n is low */
`default_nettype none

module all_channels_assert (
  input wire logic ipb_clk,
  input wire logic rst_n,
  input wire logic ipb_ack,
  input wire logic ipb_err,
  input wire logic io_wr_en,
  input wire logic dac_busy,       // shift engine of the DAC port
  input wire logic sync_n
);
  timeunit 1ns;
  timeprecision 100ps;

  // ack and err are exclusive
  a_ack_err_excl: assert property (@(posedge ipb_clk) disable iff (!rst_n)
    !(ipb_ack && ipb_err))
    else $error("ipb_ack and ipb_err high in the same cycle");

  a_ack_one_cycle: assert property (@(posedge ipb_clk) disable iff (!rst_n)
    ipb_ack |=> !ipb_ack)
    else $error("ipb_ack longer than one cycle");

  a_err_one_cycle: assert property (@(posedge ipb_clk) disable iff (!rst_n)
    ipb_err |=> !ipb_err)
    else $error("ipb_err longer than one cycle");

  a_wr_en_one_cycle: assert property (@(posedge ipb_clk) disable iff (!rst_n)
    io_wr_en |=> !io_wr_en)
    else $error("io_wr_en longer than one cycle");

  // idle DAC port keeps its frame line released
  a_sync_n_idle: assert property (@(posedge ipb_clk) disable iff (!rst_n)
    !dac_busy |-> sync_n)
    else $error("afe_dac_sync_n low while the DAC port is idle");

endmodule

bind all_channels all_channels_assert assert_i (
  .ipb_clk  (ipb_clk),
  .rst_n    (rst_n),
  .ipb_ack  (ipb_ack),
  .ipb_err  (ipb_err),
  .io_wr_en (io_wr_en),
  .dac_busy (dac_i.busy),
  .sync_n   (afe_dac_sync_n)
);

`default_nettype wire

// File: logic/all_channels.sv
/* IPbus register fabric of the channel hub, all on ipb_clk
   serial link datapaths are not part of this block */
`default_nettype none

module all_channels (
  input  logic                            ipb_clk,
  input  logic                            rst_n,
  // IPbus
  input  logic                            ipb_strobe,
  input  logic                            ipb_write,
  input  ipb_pkg::ipb_addr_t              ipb_addr,
  input  ipb_pkg::ipb_data_t              ipb_wdata,
  output ipb_pkg::ipb_data_t              ipb_rdata,
  output logic                            ipb_ack,
  output logic                            ipb_err,        // timeout on read
  // channel pins
  output logic [ipb_pkg::NUM_CHAN-1:0]    readout_pause,
  // clock synthesizer
  output logic                            adcclk_dclk,
  output logic                            adcclk_ddat,
  output logic                            adcclk_dlen,
  output logic                            adcclk_sync,
  // AFE DAC
  output logic                            afe_dac_sclk,
  output logic                            afe_dac_sdi,
  output logic                            afe_dac_sync_n
);
  import ipb_pkg::*;

  logic io_sync;
  logic io_rd_en;
  logic io_wr_en;
  logic io_rd_ack;                 // registered in the mux

  io_bus_if chan_bus [NUM_CHAN] ();
  io_bus_if synth_bus ();
  io_bus_if dac_bus ();

  ////////////////////////////////////////////////////////////////////////////
  // bus handshake and readback
  ipb_io_fsm fsm_i (
    .ipb_clk    (ipb_clk),
    .rst_n      (rst_n),
    .ipb_strobe (ipb_strobe),
    .ipb_write  (ipb_write),
    .io_rd_ack  (io_rd_ack),
    .io_sync    (io_sync),
    .io_rd_en   (io_rd_en),
    .io_wr_en   (io_wr_en),
    .ipb_ack    (ipb_ack),
    .ipb_err    (ipb_err)
  );

  io_readback_mux mux_i (
    .ipb_clk   (ipb_clk),
    .rst_n     (rst_n),
    .ipb_addr  (ipb_addr),
    .ipb_wdata (ipb_wdata),
    .io_sync   (io_sync),
    .io_rd_en  (io_rd_en),
    .io_wr_en  (io_wr_en),
    .ipb_rdata (ipb_rdata),
    .io_rd_ack (io_rd_ack),
    .chan      (chan_bus),
    .synth     (synth_bus),
    .dac       (dac_bus)
  );

  ////////////////////////////////////////////////////////////////////////////
  // slaves
  for (genvar i = 0; i < NUM_CHAN; i++) begin : g_chan
    channel_ctrl chan_i (
      .ipb_clk       (ipb_clk),
      .rst_n         (rst_n),
      .bus           (chan_bus[i]),
      .readout_pause (readout_pause[i])
    );
  end

  clk_synth_port synth_i (
    .ipb_clk (ipb_clk),
    .rst_n   (rst_n),
    .bus     (synth_bus),
    .dclk    (adcclk_dclk),
    .ddat    (adcclk_ddat),
    .dlen    (adcclk_dlen),
    .sync    (adcclk_sync)
  );

  afe_dac_port dac_i (
    .ipb_clk (ipb_clk),
    .rst_n   (rst_n),
    .bus     (dac_bus),
    .sclk    (afe_dac_sclk),
    .sdi     (afe_dac_sdi),
    .sync_n  (afe_dac_sync_n)
  );

endmodule

`default_nettype wire

// File: logic/clk_synth_port.sv
/* 32-bit synthesizer frames with active-high dlen; writes while busy are dropped */
`default_nettype none

module clk_synth_port (
  input  logic    ipb_clk,
  input  logic    rst_n,
  io_bus_if.slave bus,
  output logic    dclk,
  output logic    ddat,
  output logic    dlen,            // high during a frame
  output logic    sync             // static level from REG_SYNC
);
  import ipb_pkg::*;

  logic      busy;
  logic      frame_active;
  logic      start;
  logic      rd_req;
  logic      rd_req_q;
  logic      sync_q;
  ipb_data_t word_q;               // last accepted word

  assign start  = bus.sel & bus.wr_en & (bus.addr == REG_SHIFT_WORD) & ~busy;
  assign rd_req = bus.sel & bus.sync & bus.rd_en;

  always_ff @(posedge ipb_clk) begin
    if (start) begin
      word_q <= bus.wr_data;
    end
  end

  always_ff @(posedge ipb_clk) begin
    if (!rst_n) begin
      sync_q <= 1'b0;
    end else if (bus.sel && bus.wr_en && bus.addr == REG_SYNC) begin
      sync_q <= bus.wr_data[0];
    end
  end

  serial_shifter #(
    .FRAME_BITS (SYNTH_FRAME_BITS)
  ) shift_i (
    .ipb_clk      (ipb_clk),
    .rst_n        (rst_n),
    .start        (start),
    .word         (bus.wr_data),
    .busy         (busy),
    .sclk         (dclk),
    .sdata        (ddat),
    .frame_active (frame_active)
  );

  assign dlen = frame_active;
  assign sync = sync_q;

  always_ff @(posedge ipb_clk) begin
    if (!rst_n) begin
      rd_req_q   <= 1'b0;
      bus.rd_ack <= 1'b0;
    end else begin
      rd_req_q   <= rd_req;
      bus.rd_ack <= rd_req & ~rd_req_q;
    end
  end

  always_ff @(posedge ipb_clk) begin
    if (rd_req && !rd_req_q) begin
      case (bus.addr)
        REG_SHIFT_WORD: bus.rd_data <= word_q;
        REG_STATUS:     bus.rd_data <= {31'd0, busy};
        REG_SYNC:       bus.rd_data <= {31'd0, sync_q};
        default:        bus.rd_data <= '0;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: logic/afe_dac_port.sv
/* 24-bit DAC frames framed by sync_n; a word written while busy is dropped */
`default_nettype none

module afe_dac_port (
  input  logic    ipb_clk,
  input  logic    rst_n,
  io_bus_if.slave bus,
  output logic    sclk,
  output logic    sdi,
  output logic    sync_n           // low during a frame
);
  import ipb_pkg::*;

  logic      busy;
  logic      frame_active;
  logic      start;                // accepted shift-word write
  logic      rd_req;
  logic      rd_req_q;
  ipb_data_t word_q;               // last accepted word

  assign start  = bus.sel & bus.wr_en & (bus.addr == REG_SHIFT_WORD) & ~busy;
  assign rd_req = bus.sel & bus.sync & bus.rd_en;

  always_ff @(posedge ipb_clk) begin
    if (start) begin
      word_q <= bus.wr_data;
    end
  end

  serial_shifter #(
    .FRAME_BITS (DAC_FRAME_BITS)
  ) shift_i (
    .ipb_clk      (ipb_clk),
    .rst_n        (rst_n),
    .start        (start),
    .word         (bus.wr_data),
    .busy         (busy),
    .sclk         (sclk),
    .sdata        (sdi),
    .frame_active (frame_active)
  );

  assign sync_n = ~frame_active;

  always_ff @(posedge ipb_clk) begin
    if (!rst_n) begin
      rd_req_q   <= 1'b0;
      bus.rd_ack <= 1'b0;
    end else begin
      rd_req_q   <= rd_req;
      bus.rd_ack <= rd_req & ~rd_req_q;  // single pulse per read
    end
  end

  always_ff @(posedge ipb_clk) begin
    if (rd_req && !rd_req_q) begin
      case (bus.addr)
        REG_SHIFT_WORD: bus.rd_data <= word_q;
        REG_STATUS:     bus.rd_data <= {31'd0, busy};
        default:        bus.rd_data <= '0;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: logic/serial_shifter.sv
/* MSB-first, FRAME_BITS of 32 at most, 2*SCLK_DIV clocks per bit, SCLK_DIV >= 2
   data changes on falling sclk; start is ignored while busy */
`default_nettype none

module serial_shifter #(
  parameter int FRAME_BITS = 24
) (
  input  logic               ipb_clk,
  input  logic               rst_n,
  input  logic               start,         // load word and begin frame
  input  ipb_pkg::ipb_data_t word,          // low FRAME_BITS are sent
  output logic               busy,
  output logic               sclk,
  output logic               sdata,
  output logic               frame_active   // high for the whole frame
);
  import ipb_pkg::*;

  localparam int DIV_W = $clog2(SCLK_DIV);
  localparam int BIT_W = $clog2(FRAME_BITS);

  logic [DIV_W-1:0]      div_cnt;           // half-period divider
  logic [BIT_W-1:0]      bit_cnt;           // bits already sent
  logic [FRAME_BITS-1:0] shreg;
  logic                  busy_q;
  logic                  sclk_q;
  logic                  half_end;          // last cycle of a half period

  assign half_end = (div_cnt == DIV_W'(SCLK_DIV - 1));

  always_ff @(posedge ipb_clk) begin
    if (!rst_n) begin
      busy_q  <= 1'b0;
      sclk_q  <= 1'b0;
      div_cnt <= '0;
      bit_cnt <= '0;
    end else if (!busy_q) begin
      busy_q  <= start;
      sclk_q  <= 1'b0;
      div_cnt <= '0;
      bit_cnt <= '0;
    end else if (half_end) begin
      div_cnt <= '0;
      sclk_q  <= ~sclk_q;                   // toggle every half period
      if (sclk_q) begin                     // falling edge ends a bit
        if (bit_cnt == BIT_W'(FRAME_BITS - 1)) begin
          busy_q <= 1'b0;                   // frame done
        end else begin
          bit_cnt <= bit_cnt + 1'b1;
        end
      end
    end else begin
      div_cnt <= div_cnt + 1'b1;
    end
  end

  always_ff @(posedge ipb_clk) begin
    if (start && !busy_q) begin
      shreg <= word[FRAME_BITS-1:0];
    end else if (busy_q && half_end && sclk_q) begin
      shreg <= {shreg[FRAME_BITS-2:0], 1'b0};  // next bit on falling sclk
    end
  end

  assign busy         = busy_q;
  assign sclk         = sclk_q;
  assign sdata        = busy_q & shreg[FRAME_BITS-1];  // idle low
  assign frame_active = busy_q;

endmodule

`default_nettype wire

// File: logic/channel_ctrl.sv
/* two registers per channel; unknown offsets read zero and ignore writes */
`default_nettype none

module channel_ctrl (
  input  logic    ipb_clk,
  input  logic    rst_n,
  io_bus_if.slave bus,
  output logic    readout_pause    // stops data from this channel
);
  import ipb_pkg::*;

  ipb_data_t ctrl_q;               // bit 0 pause
  ipb_data_t scratch_q;
  logic      rd_req;
  logic      rd_req_q;             // for first-cycle detect

  assign rd_req = bus.sel & bus.sync & bus.rd_en;

  always_ff @(posedge ipb_clk) begin
    if (!rst_n) begin
      ctrl_q    <= '0;
      scratch_q <= '0;
    end else if (bus.sel && bus.wr_en) begin
      case (bus.addr)
        REG_CTRL:    ctrl_q    <= bus.wr_data;
        REG_SCRATCH: scratch_q <= bus.wr_data;
        default:     ;                          // unmapped, dropped
      endcase
    end
  end

  // one ack per read, on the cycle after the request appears
  always_ff @(posedge ipb_clk) begin
    if (!rst_n) begin
      rd_req_q   <= 1'b0;
      bus.rd_ack <= 1'b0;
    end else begin
      rd_req_q   <= rd_req;
      bus.rd_ack <= rd_req & ~rd_req_q;
    end
  end

  always_ff @(posedge ipb_clk) begin
    if (rd_req && !rd_req_q) begin
      case (bus.addr)
        REG_CTRL:    bus.rd_data <= ctrl_q;
        REG_SCRATCH: bus.rd_data <= scratch_q;
        default:     bus.rd_data <= '0;
      endcase
    end
  end

  assign readout_pause = ctrl_q[0];

endmodule

`default_nettype wire

// File: logic/io_readback_mux.sv
/* decodes address bits 23:20 and registers the answering slave's data and ack
   assumes at most one slave acks at a time; reserved regions never ack */
`default_nettype none

module io_readback_mux (
  input  logic               ipb_clk,
  input  logic               rst_n,
  input  ipb_pkg::ipb_addr_t ipb_addr,
  input  ipb_pkg::ipb_data_t ipb_wdata,
  input  logic               io_sync,
  input  logic               io_rd_en,
  input  logic               io_wr_en,
  output ipb_pkg::ipb_data_t ipb_rdata,
  output logic               io_rd_ack,
  io_bus_if.host             chan [ipb_pkg::NUM_CHAN],
  io_bus_if.host             synth,
  io_bus_if.host             dac
);
  import ipb_pkg::*;

  localparam int NUM_SLV = NUM_CHAN + 2;  // channels, synth, dac

  io_region_e         region;
  logic [NUM_SLV-1:0] slv_ack;            // collected acks
  ipb_data_t          slv_data [NUM_SLV];
  ipb_data_t          rdata_q;
  logic               ack_q;

  assign region = io_region_e'(ipb_addr[23:20]);

  ////////////////////////////////////////////////////////////////////////////
  // fan-out to the slaves
  for (genvar i = 0; i < NUM_CHAN; i++) begin : g_chan
    assign chan[i].sel     = (region == io_region_e'(4'(i)));
    assign chan[i].sync    = io_sync;
    assign chan[i].rd_en   = io_rd_en;
    assign chan[i].wr_en   = io_wr_en;
    assign chan[i].addr    = ipb_addr[19:0];
    assign chan[i].wr_data = ipb_wdata;
    assign slv_ack[i]      = chan[i].rd_ack;
    assign slv_data[i]     = chan[i].rd_data;
  end

  assign synth.sel     = (region == REGION_CLK_SYNTH);
  assign synth.sync    = io_sync;
  assign synth.rd_en   = io_rd_en;
  assign synth.wr_en   = io_wr_en;
  assign synth.addr    = ipb_addr[19:0];
  assign synth.wr_data = ipb_wdata;
  assign slv_ack[NUM_CHAN]  = synth.rd_ack;
  assign slv_data[NUM_CHAN] = synth.rd_data;

  assign dac.sel     = (region == REGION_AFE_DAC);
  assign dac.sync    = io_sync;
  assign dac.rd_en   = io_rd_en;
  assign dac.wr_en   = io_wr_en;
  assign dac.addr    = ipb_addr[19:0];
  assign dac.wr_data = ipb_wdata;
  assign slv_ack[NUM_CHAN+1]  = dac.rd_ack;
  assign slv_data[NUM_CHAN+1] = dac.rd_data;

  ////////////////////////////////////////////////////////////////////////////
  // readback registers
  always_ff @(posedge ipb_clk) begin
    if (!rst_n) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= io_sync & io_rd_en & (|slv_ack);  // only while a read waits
    end
  end

  always_ff @(posedge ipb_clk) begin
    for (int k = 0; k < NUM_SLV; k++) begin
      if (slv_ack[k]) begin
        rdata_q <= slv_data[k];                  // keep last answer
      end
    end
  end

  assign ipb_rdata = rdata_q;
  assign io_rd_ack = ack_q;

endmodule

`default_nettype wire

// File: logic/ipb_io_fsm.sv
/* one access per strobe; strobe must fall before the next access starts
   writes are acked without a slave answer, reads time out into ipb_err */
`default_nettype none

module ipb_io_fsm (
  input  logic ipb_clk,
  input  logic rst_n,
  input  logic ipb_strobe,      // access request from IPbus
  input  logic ipb_write,       // 1 write, 0 read
  input  logic io_rd_ack,       // registered ack from the mux
  output logic io_sync,         // access in progress
  output logic io_rd_en,        // read held while waiting
  output logic io_wr_en,        // single-cycle write strobe
  output logic ipb_ack,
  output logic ipb_err
);
  import ipb_pkg::*;

  localparam int WAIT_W = $clog2(IO_TIMEOUT);

  io_fsm_state_e     state;
  io_fsm_state_e     state_nxt;
  logic [WAIT_W-1:0] wait_cnt;  // cycles spent in READ_WAIT

  always_ff @(posedge ipb_clk) begin
    if (!rst_n) begin
      state <= IDLE;
    end else begin
      state <= state_nxt;
    end
  end

  always_comb begin
    state_nxt = state;
    case (state)
      IDLE: begin
        if (ipb_strobe) begin
          state_nxt = ipb_write ? WRITE : READ_WAIT;
        end
      end
      WRITE:     state_nxt = ACK;                       // wr_en lasts one cycle
      READ_WAIT: begin
        if (io_rd_ack) begin
          state_nxt = ACK;                              // ack wins over timeout
        end else if (wait_cnt == WAIT_W'(IO_TIMEOUT - 1)) begin
          state_nxt = ERR;                              // nobody answered
        end
      end
      ACK:       state_nxt = HOLD;
      ERR:       state_nxt = HOLD;
      HOLD: begin
        if (!ipb_strobe) begin
          state_nxt = IDLE;                             // wait for strobe release
        end
      end
      default:   state_nxt = IDLE;
    endcase
  end

  // timeout counter, cleared outside the read wait
  always_ff @(posedge ipb_clk) begin
    if (!rst_n) begin
      wait_cnt <= '0;
    end else if (state != READ_WAIT) begin
      wait_cnt <= '0;
    end else begin
      wait_cnt <= wait_cnt + 1'b1;
    end
  end

  assign io_sync  = (state == WRITE) || (state == READ_WAIT);
  assign io_rd_en = (state == READ_WAIT);
  assign io_wr_en = (state == WRITE);
  assign ipb_ack  = (state == ACK);
  assign ipb_err  = (state == ERR);

endmodule

`default_nettype wire

// File: logic/io_bus_if.sv
/* register-access link between the readback mux and one slave
   rd_ack is a single-cycle pulse with rd_data stable in that cycle */
`default_nettype none

interface io_bus_if;
  import ipb_pkg::*;

  logic      sel;       // region decode hit
  logic      sync;      // access in progress
  logic      rd_en;     // read access
  logic      wr_en;     // one-cycle write strobe
  io_addr_t  addr;      // offset in region
  ipb_data_t wr_data;
  ipb_data_t rd_data;   // valid with rd_ack
  logic      rd_ack;    // read answer pulse

  modport host (
    output sel, sync, rd_en, wr_en, addr, wr_data,
    input  rd_data, rd_ack
  );

  modport slave (
    input  sel, sync, rd_en, wr_en, addr, wr_data,
    output rd_data, rd_ack
  );

endinterface

`default_nettype wire

// File: logic/ipb_pkg.sv
/* shared by RTL and testbench; region codes 7..15 are reserved and select no slave
   SCLK_DIV must be 2 or more, frame sizes at most 32 bits */
`default_nettype none

package ipb_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // bus types
  typedef logic [23:0] ipb_addr_t;      // full IPbus address
  typedef logic [31:0] ipb_data_t;      // one data word
  typedef logic [19:0] io_addr_t;       // offset inside a region

  // address bits 23:20
  typedef enum logic [3:0] {
    REGION_CHAN0     = 4'd0,
    REGION_CHAN1     = 4'd1,
    REGION_CHAN2     = 4'd2,
    REGION_CHAN3     = 4'd3,
    REGION_CHAN4     = 4'd4,
    REGION_CLK_SYNTH = 4'd5,
    REGION_AFE_DAC   = 4'd6
  } io_region_e;

  localparam int NUM_CHAN = 5;          // channel slaves behind the hub

  ////////////////////////////////////////////////////////////////////////////
  // handshake FSM
  typedef enum logic [2:0] {
    IDLE,
    WRITE,
    READ_WAIT,
    ACK,
    ERR,
    HOLD
  } io_fsm_state_e;

  localparam int IO_TIMEOUT = 16;       // read-wait cycles before ipb_err

  ////////////////////////////////////////////////////////////////////////////
  // serial ports
  localparam int SCLK_DIV         = 4;  // ipb_clk cycles per half period
  localparam int DAC_FRAME_BITS   = 24;
  localparam int SYNTH_FRAME_BITS = 32;

  ////////////////////////////////////////////////////////////////////////////
  // register offsets
  localparam io_addr_t REG_CTRL       = 20'd0;  // bit 0 pause
  localparam io_addr_t REG_SCRATCH    = 20'd1;
  localparam io_addr_t REG_SHIFT_WORD = 20'd0;  // serial ports
  localparam io_addr_t REG_STATUS     = 20'd1;  // bit 0 busy
  localparam io_addr_t REG_SYNC       = 20'd2;  // synth only, bit 0 level

endpackage

`default_nettype wire
